// ==== Bender.yml ====
package:
  name: router_alloc

sources:
  - hdl/routerPkg.sv
  - hdl/timerIf.sv
  - hdl/headerDecode.sv
  - hdl/portTimer.sv
  - hdl/switchArbiter.sv
  - hdl/routerAlloc.sv
  - target: test
    files:
      - bench/clockGen.sv
      - bench/alloc_checker.sv
      - bench/routerAllocTb.sv

// ==== bench/alloc_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module allocChecker (
  input logic                           clk,
  input logic                           rst,
  input logic [routerPkg::numPorts-1:0] req,
  input logic [routerPkg::numPorts-1:0] grant
);

  int assertErrs = 0;   // Failed assertions so far

  oneGrant: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else
    begin
      assertErrs++;
      $error("grant is not one-hot or zero: %b", grant);
    end

  // Grant only follows a request seen at the previous edge
  grantHasReq: assert property (@(posedge clk) disable iff (rst)
    (grant & ~$past(req)) == '0)
    else
    begin
      assertErrs++;
      $error("grant %b given without a request", grant);
    end

  idleAfterReset: assert property (@(posedge clk) $past(rst) |-> grant == '0)
    else
    begin
      assertErrs++;
      $error("grant %b is not zero right after reset", grant);
    end

endmodule

bind routerAlloc allocChecker u_checker (
  .clk   (clk),
  .rst   (rst),
  .req   (req),
  .grant (grant)
);

`default_nettype wire

// ==== bench/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
  parameter int period      = 100,
  parameter int resetCycles = 2
) (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (resetCycles) @(posedge clk);
    #1 rst = 1'b0;       // Released with the other inputs
  end

endmodule

`default_nettype wire

// ==== bench/routerAllocTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module routerAllocTb;

  import routerPkg::*;

  typedef struct packed {
    logic [4:0]       hdr;      // Header ports in the first cycle
    logic [4:0][11:0] len;
    logic [4:0]       req;
    logic [7:0]       cycles;
    logic [4:0][2:0]  stray;    // Ids in the second cycle
    logic             rnd;      // Requests from the LFSR
  } rowT;

  logic                      clk;
  logic                      rst;
  logic [numPorts-1:0][2:0]  flitId;
  logic [numPorts-1:0][11:0] length;
  logic [numPorts-1:0]       req;
  logic [numPorts-1:0]       grant;
  logic [numPorts-1:0]       protocolErr;
  logic [numPorts-1:0]       refOpen = '0;
  logic [numPorts-1:0]       refErr = '0;
  logic [31:0]               lfsr = 32'hb8c8_6960;
  logic                      tableLoaded = 1'b0;
  int                        refLimit [numPorts] = '{default: 0};
  int                        refCount [numPorts] = '{default: 0};
  int                        refSt = 0;   // 0 idle, else port + 1
  int                        totalCycles = 0;
  int                        grantErrs = 0;
  int                        flagErrs = 0;
  rowT                       rows [$];

  clockGen #(.period(100), .resetCycles(2)) u_clk (.clk(clk), .rst(rst));

  routerAlloc #(
    .lengthW (12)
  ) u_dut (
    .clk         (clk),
    .rst         (rst),
    .flitId      (flitId),
    .length      (length),
    .req         (req),
    .grant       (grant),
    .protocolErr (protocolErr)
  );

  function automatic logic [31:0] lfsrNext(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task automatic randomReq(output logic [numPorts-1:0] mask);
    for (int k = 0; k < numPorts; k++)
    begin
      lfsr    = lfsrNext(lfsr);   // One step per bit
      mask[k] = lfsr[0];
    end
  endtask

  task automatic addRow(logic [4:0] hdr, logic [4:0][11:0] len, logic [4:0] rq,
                        int cyc, logic [4:0][2:0] stray, logic rnd);
    rows.push_back({hdr, len, rq, cyc[7:0], stray, rnd});
    totalCycles += cyc;
  endtask

  // Reference allocator, one call per rising edge
  task automatic modelStep;
    logic [numPorts-1:0] run;
    int nxt;
    int cur;
    int span;
    run  = '0;
    nxt  = 0;
    cur  = refSt - 1;
    span = (refSt == 0) ? numPorts : numPorts - 1;
    if (refSt != 0 && req[cur] && refCount[cur] != refLimit[cur])
    begin
      run[cur] = 1'b1;
      nxt      = refSt;
    end
    else
    begin
      for (int k = 1; k <= span; k++)   // From idle this scans L first
      begin
        if (nxt == 0 && req[(cur + k + numPorts) % numPorts])
        begin
          nxt = (cur + k + numPorts) % numPorts + 1;
        end
      end
    end
    for (int p = 0; p < numPorts; p++)
    begin
      refErr[p]   = (flitId[p] > 3'd3) ||
                    ((flitId[p] == flitBody || flitId[p] == flitTail) && !refOpen[p]);
      refOpen[p]  = (refOpen[p] || flitId[p] == flitHeader) && flitId[p] != flitTail;
      refLimit[p] = (flitId[p] == flitHeader) ? length[p] : refLimit[p];
      refCount[p] = run[p] ? (refCount[p] + 1) % 4096 : 0;
    end
    refSt = nxt;
  endtask

  task automatic checkOutputs;
    logic [numPorts-1:0] expGrant;
    expGrant = (refSt == 0) ? '0 : (5'b1 << (refSt - 1));
    for (int p = 0; p < numPorts; p++)
    begin
      assert (grant[p] === expGrant[p])
      else
      begin
        grantErrs++;
        $display("FAIL %0d ns: grant on port %0d is %b, expected %b",
                 $time, p, grant[p], expGrant[p]);
      end
      assert (protocolErr[p] === refErr[p])
      else
      begin
        flagErrs++;
        $display("FAIL %0d ns: protocolErr on port %0d is %b, expected %b",
                 $time, p, protocolErr[p], refErr[p]);
      end
    end
  endtask

  initial
  begin
    flitId = '0;
    length = '0;
    req    = '0;
    // Lengths and stray ids are written S first, L last
    addRow(5'b00000, '0, 5'b00000, 4, '0, 1'b0);                        // No traffic
    addRow(5'b00000, '0, 5'b00000, 3, {3'd5, 3'd0, 3'd0, 3'd2, 3'd0}, 1'b0);
    addRow(5'b11111, {12'd2, 12'd0, 12'd3, 12'd1, 12'd2}, 5'b11111, 30, '0, 1'b0);
    addRow(5'b00000, '0, 5'b00000, 3, '0, 1'b0);
    addRow(5'b11111, {5{12'd3}}, 5'b00100, 12, '0, 1'b0);               // Lone E
    addRow(5'b11111, {5{12'd8}}, 5'b00011, 4, '0, 1'b0);
    addRow(5'b00000, {5{12'd8}}, 5'b00010, 6, '0, 1'b0);                // L drops early
    addRow(5'b00100, {5{12'd1}}, 5'b00000, 3, {3'd0, 3'd0, 3'd3, 3'd0, 3'd0}, 1'b0);
    addRow(5'b00000, '0, 5'b00000, 2, {3'd0, 3'd0, 3'd2, 3'd0, 3'd0}, 1'b0);
    addRow(5'b11111, {12'd3, 12'd1, 12'd2, 12'd0, 12'd1}, 5'b00000, 60, '0, 1'b1);
    tableLoaded = 1'b1;
    @(negedge rst);
    foreach (rows[r])
    begin
      for (int c = 0; c < rows[r].cycles; c++)
      begin
        flitId = (c == 1) ? rows[r].stray : '0;
        for (int p = 0; p < numPorts; p++)
        begin
          if (c == 0 && rows[r].hdr[p])
          begin
            flitId[p] = flitHeader;
          end
        end
        length = rows[r].len;
        if (rows[r].rnd)
        begin
          randomReq(req);
        end
        else
        begin
          req = rows[r].req;
        end
        @(negedge clk);
        checkOutputs();
        @(posedge clk);
        modelStep();
        #1;
      end
    end
    @(negedge clk);
    checkOutputs();
    $display("Errors: grant %0d, protocolErr %0d, assertions %0d",
             grantErrs, flagErrs, u_dut.u_checker.assertErrs);
    if (grantErrs + flagErrs + u_dut.u_checker.assertErrs == 0)
    begin
      $display("TEST PASSED");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial
  begin
    wait (tableLoaded);
    #((totalCycles + 22) * 100);   // Reset cycles plus margin
    $display("Watchdog expired before the scenario table finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/headerDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module headerDecode #(
  parameter int lengthW = 12
) (
  input  logic                                                            clk,
  input  logic                                                            rst,
  input  logic [routerPkg::numPorts-1:0][$bits(routerPkg::flitKind)-1:0] flitId,
  input  logic [routerPkg::numPorts-1:0][lengthW-1:0]                    length,
  timerIf.decoder                                                         tmr [routerPkg::numPorts],
  output logic [routerPkg::numPorts-1:0]                                 protocolErr
);

  import routerPkg::*;

  logic [numPorts-1:0] openPkt;      // Header seen, tail not yet
  logic [numPorts-1:0] headerSeen;
  logic [numPorts-1:0] tailSeen;
  logic [numPorts-1:0] errNext;

  for (genvar i = 0; i < numPorts; i++)
  begin : gPort
    flitKind kind;
    logic    badFlit;

    assign kind = flitKind'(flitId[i]);

    // Limit is captured by the timer on the header cycle
    assign tmr[i].loadLength = (kind == flitHeader);
    assign tmr[i].length     = length[i];

    always_comb
    begin
      case (kind)
        flitNone, flitHeader:
          badFlit = 1'b0;
        flitBody, flitTail:
          badFlit = !openPkt[i];    // No packet open on this port
        default:
          badFlit = 1'b1;           // Id outside the enum
      endcase
    end

    assign headerSeen[i] = (kind == flitHeader);
    assign tailSeen[i]   = (kind == flitTail);
    assign errNext[i]    = badFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      openPkt     <= '0;
      protocolErr <= '0;
    end
    else
    begin
      protocolErr <= errNext;                             // One-cycle pulse
      openPkt     <= (openPkt | headerSeen) & ~tailSeen;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/portTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

module portTimer #(
  parameter int lengthW = 12
) (
  input  logic   clk,
  input  logic   rst,
  timerIf.timer  tmr
);

  logic [lengthW-1:0] limit;   // Packet length from the last header
  logic [lengthW-1:0] count;   // Granted cycles so far

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (tmr.loadLength)
      begin
        limit <= tmr.length;
      end

      if (tmr.runTimer)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;       // Restart for the next grant
      end
    end
  end

  // A zero limit expires in the first granted cycle
  assign tmr.timesUp = (count == limit);

endmodule

`default_nettype wire

// ==== hdl/routerAlloc.sv ====
`timescale 1ns/1ps
`default_nettype none

module routerAlloc #(
  parameter int lengthW = 12
) (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic [routerPkg::numPorts-1:0][2:0]          flitId,
  input  logic [routerPkg::numPorts-1:0][lengthW-1:0]  length,
  input  logic [routerPkg::numPorts-1:0]               req,
  output logic [routerPkg::numPorts-1:0]               grant,
  output logic [routerPkg::numPorts-1:0]               protocolErr
);

  import routerPkg::*;

  // One decoder-timer-arbiter link per port
  timerIf #(
    .lengthW (lengthW)
  ) tmrBus [numPorts] ();

  headerDecode #(
    .lengthW (lengthW)
  ) u_decode (
    .clk         (clk),
    .rst         (rst),
    .flitId      (flitId),
    .length      (length),
    .tmr         (tmrBus),
    .protocolErr (protocolErr)
  );

  for (genvar i = 0; i < numPorts; i++)
  begin : gTimer
    portTimer #(
      .lengthW (lengthW)
    ) u_timer (
      .clk (clk),
      .rst (rst),
      .tmr (tmrBus[i])
    );
  end

  switchArbiter u_arbiter (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .tmr   (tmrBus),
    .grant (grant)
  );

endmodule

`default_nettype wire

// ==== hdl/routerPkg.sv ====
`default_nettype none

package routerPkg;

  localparam int numPorts = 5;

  // Port order, also the fixed priority from idle and the rotation order
  typedef enum logic [2:0] {
    portL = 3'd0,
    portN = 3'd1,
    portE = 3'd2,
    portW = 3'd3,
    portS = 3'd4
  } portIdx;

  // Flit id carried with every flit on a port
  typedef enum logic [2:0] {
    flitNone   = 3'd0,
    flitHeader = 3'd1,
    flitBody   = 3'd2,
    flitTail   = 3'd3
  } flitKind;

  // One-hot allocator states, bit 0 is idle, bits 1 to 5 follow port order
  typedef enum logic [numPorts:0] {
    stIdle = 6'b000001,
    stL    = 6'b000010,
    stN    = 6'b000100,
    stE    = 6'b001000,
    stW    = 6'b010000,
    stS    = 6'b100000
  } arbState;

endpackage

`default_nettype wire

// ==== hdl/switchArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module switchArbiter (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [routerPkg::numPorts-1:0] req,
  timerIf.arbiter                        tmr [routerPkg::numPorts],
  output logic [routerPkg::numPorts-1:0] grant
);

  import routerPkg::*;

  arbState             state;
  arbState             nextState;
  portIdx              curPort;
  logic [numPorts-1:0] runTimer;
  logic [numPorts-1:0] timesUp;

  function automatic arbState portState(int unsigned p);
    case (p)
      portL:   return stL;
      portN:   return stN;
      portE:   return stE;
      portW:   return stW;
      portS:   return stS;
      default: return stIdle;
    endcase
  endfunction

  function automatic portIdx statePort(arbState s);
    case (s)
      stN:     return portN;
      stE:     return portE;
      stW:     return portW;
      stS:     return portS;
      default: return portL;
    endcase
  endfunction

  // First requester among span ports, starting at first and wrapping
  function automatic arbState searchFrom(
    logic [numPorts-1:0] r,
    int unsigned         first,
    int unsigned         span
  );
    arbState     pick;
    int unsigned idx;
    logic        found;

    pick  = stIdle;
    found = 1'b0;
    for (int unsigned k = 0; k < numPorts; k++)
    begin
      idx = (first + k) % numPorts;
      if (!found && (k < span) && r[idx])
      begin
        pick  = portState(idx);
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  for (genvar i = 0; i < numPorts; i++)
  begin : gPort
    assign timesUp[i]      = tmr[i].timesUp;
    assign tmr[i].runTimer = runTimer[i];
  end

  assign curPort = statePort(state);

  always_comb
  begin
    nextState = stIdle;
    runTimer  = '0;
    case (state)
      stIdle:
      begin
        nextState = searchFrom(req, portL, numPorts);   // Fixed priority L first
      end
      stL, stN, stE, stW, stS:
      begin
        if (req[curPort] && !timesUp[curPort])
        begin
          runTimer[curPort] = 1'b1;
          nextState         = state;
        end
        else
        begin
          // Rotate past the current port, idle if nobody else asks
          nextState = searchFrom(req, curPort + 1, numPorts - 1);
        end
      end
      default:
      begin
        nextState = stIdle;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= stIdle;
    end
    else
    begin
      state <= nextState;
    end
  end

  assign grant = state[numPorts:1];   // Port bits of the one-hot state

endmodule

`default_nettype wire

// ==== hdl/timerIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface timerIf #(
  parameter int lengthW = 12
) ();

  logic               loadLength;   // Header strobe
  logic [lengthW-1:0] length;
  logic               runTimer;     // Port holds the switch
  logic               timesUp;

  modport decoder (
    output loadLength,
    output length
  );

  modport timer (
    input  loadLength,
    input  length,
    input  runTimer,
    output timesUp
  );

  modport arbiter (
    output runTimer,
    input  timesUp
  );

endinterface

`default_nettype wire

// ==== list.f ====
hdl/routerPkg.sv
hdl/timerIf.sv
hdl/headerDecode.sv
hdl/portTimer.sv
hdl/switchArbiter.sv
hdl/routerAlloc.sv
bench/clockGen.sv
bench/alloc_checker.sv
bench/routerAllocTb.sv
